// ==== vlog.f ====
fetch_pkg.sv
icache.sv
inst_mem.sv
fetch_unit.sv
fetch_top.sv
tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_fetch -o tb_fetch || exit 1
sim_out="$(./obj_dir/tb_fetch 2>&1)"
echo "$sim_out"
grep -qx "SIMULATION PASSED" <<< "$sim_out" && exit 0 || exit 1

// ==== tb_fetch.sv ====
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

	localparam int mem_latency = 3;
	localparam int mem_words   = 256;
	localparam int period      = 4;
	localparam int lines       = 2 ** index_len;

	// deliveries per test, the ones dropped by a redirect included
	localparam int fetch_budget = 20 + 13 + 18 + 11 + 36;
	localparam int timeout = (fetch_budget * (mem_latency + 8) + 8 + 200) * period;

	logic              clock;
	logic              reset;
	logic              redirect;
	logic [addr_w-1:0] redirect_pc;
	fetch_out_t        fetch_out;
	logic              inst_valid;
	logic              inst_ready;

	// scoreboard
	logic [addr_w-1:0]  exp_pc;
	logic [lines-1:0]   model_valid;
	logic [tag_len-1:0] model_tag [lines];
	logic               exp_hit;
	logic               exp_fault;
	logic [addr_w-1:0]  exp_inst;

	int accepted;
	int errors;
	int errors_before;
	int tests_done;

	fetch_top #(
		.mem_latency(mem_latency),
		.mem_words(mem_words)
	) dut (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.fetch_out(fetch_out),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready)
	);

	function automatic logic [addr_w-1:0] expected_word(input logic [addr_w-1:0] addr);
		return addr ^ mem_pattern;
	endfunction

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		#(timeout);
		$display("watchdog: fetch path stopped delivering, run aborted at %0t", $time);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ########################################
	// reference model

	always_comb begin
		exp_inst  = expected_word(exp_pc);
		exp_fault = exp_pc >= addr_w'(mem_words * 4);
		exp_hit   = model_valid[exp_pc[offset_len +: index_len]] &&
			model_tag[exp_pc[offset_len +: index_len]] == exp_pc[addr_w-1 -: tag_len];
	end

	always @(posedge clock) begin
		if (reset) begin
			exp_pc      <= '0;
			model_valid <= '0;
			accepted    <= 0;
		end else begin
			if (redirect)
				exp_pc <= redirect_pc;
			else if (inst_valid && inst_ready)
				exp_pc <= exp_pc + 4;
			// a miss was filled even if the delivery is dropped
			if (inst_valid && (inst_ready || redirect) && !exp_hit && !exp_fault) begin
				model_valid[exp_pc[offset_len +: index_len]] <= 1'b1;
				model_tag[exp_pc[offset_len +: index_len]]   <= exp_pc[addr_w-1 -: tag_len];
			end
			if (inst_valid && inst_ready && !redirect)
				accepted <= accepted + 1;
		end
	end

	// ########################################
	// checks

	a_pc: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> fetch_out.pc == exp_pc)
		else begin
			errors++;
			$display("[ERROR] %0t pc %h, expected %h", $time, $sampled(fetch_out.pc),
				$sampled(exp_pc));
		end

	a_inst: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !exp_fault |-> fetch_out.inst == exp_inst)
		else begin
			errors++;
			$display("[ERROR] %0t inst %h at pc %h, expected %h", $time,
				$sampled(fetch_out.inst), $sampled(fetch_out.pc), $sampled(exp_inst));
		end

	a_fault: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> fetch_out.fault == exp_fault)
		else begin
			errors++;
			$display("[ERROR] %0t fault flag %b at pc %h", $time, $sampled(fetch_out.fault),
				$sampled(fetch_out.pc));
		end

	a_hit: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> fetch_out.hit == exp_hit)
		else begin
			errors++;
			$display("[ERROR] %0t hit flag %b at pc %h, expected %b", $time,
				$sampled(fetch_out.hit), $sampled(fetch_out.pc), $sampled(exp_hit));
		end

	a_hold: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(fetch_out))
		else begin
			errors++;
			$display("[ERROR] %0t output changed while stalled", $time);
		end

	// ########################################
	// stimulus

	task automatic take_fetches(input int n);
		int target;
		target = accepted + n;
		while (accepted < target) begin
			@(negedge clock);
			inst_ready = ($urandom % 4) != 0; // stall about one cycle in four
		end
	endtask

	// pulse while a delivery is held, so nothing is in flight
	task automatic redirect_to(input logic [addr_w-1:0] target);
		inst_ready = 1'b0;
		@(negedge clock);
		while (!inst_valid)
			@(negedge clock);
		redirect    = 1'b1;
		redirect_pc = target;
		@(negedge clock);
		redirect = 1'b0;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d %s: %0d error(s)", tests_done, name, errors - errors_before);
		errors_before = errors;
	endtask

	initial begin
		void'($urandom(98));
		reset         = 1'b1;
		redirect      = 1'b0;
		redirect_pc   = '0;
		inst_ready    = 1'b0;
		errors        = 0;
		errors_before = 0;
		tests_done    = 0;
		repeat (8) @(negedge clock);
		reset = 1'b0;

		take_fetches(20); // wraps the 16 lines
		finish_test("sequential from reset");

		redirect_to(32'h10);
		take_fetches(12);
		finish_test("refetch after redirect");

		redirect_to(32'h100); // same indices, other tag
		take_fetches(8);
		redirect_to(32'h0);
		take_fetches(8);
		finish_test("aliased lines");

		redirect_to(mem_words * 4 - 8);
		take_fetches(4);
		redirect_to(mem_words * 4);
		take_fetches(2);
		redirect_to(mem_words * 4 - 8);
		take_fetches(2);
		finish_test("fault region");

		repeat (6) begin
			redirect_to(($urandom % 300) * 4);
			take_fetches(5);
		end
		finish_test("random redirects");

		$display("%0d tests, %0d instructions accepted, %0d errors", tests_done, accepted, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int mem_latency = 3,
	parameter int mem_words   = 256
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect,
	input  logic [addr_w-1:0] redirect_pc,
	output fetch_out_t        fetch_out,
	output logic              inst_valid,
	input  logic              inst_ready
);

	// fetch to cache
	ar_chan_t c_ar;
	r_chan_t  c_r;
	aw_chan_t c_aw;
	w_chan_t  c_w;
	logic     c_arvalid, c_arready, c_rvalid, c_rready;
	logic     c_awvalid, c_awready, c_wvalid, c_wready, c_bvalid, c_bready;

	// fetch to memory
	ar_chan_t m_ar;
	r_chan_t  m_r;
	logic     m_arvalid, m_arready, m_rvalid, m_rready;

	fetch_unit u_fetch (
		.clock(clock), .reset(reset),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.c_ar(c_ar), .c_arvalid(c_arvalid), .c_arready(c_arready),
		.c_r(c_r), .c_rvalid(c_rvalid), .c_rready(c_rready),
		.c_aw(c_aw), .c_awvalid(c_awvalid), .c_awready(c_awready),
		.c_w(c_w), .c_wvalid(c_wvalid), .c_wready(c_wready),
		.c_bvalid(c_bvalid), .c_bready(c_bready),
		.m_ar(m_ar), .m_arvalid(m_arvalid), .m_arready(m_arready),
		.m_r(m_r), .m_rvalid(m_rvalid), .m_rready(m_rready),
		.fetch_out(fetch_out), .inst_valid(inst_valid), .inst_ready(inst_ready)
	);

	icache u_icache (
		.clock(clock), .reset(reset),
		.ar(c_ar), .arvalid(c_arvalid), .arready(c_arready),
		.r(c_r), .rvalid(c_rvalid), .rready(c_rready),
		.aw(c_aw), .awvalid(c_awvalid), .awready(c_awready),
		.w(c_w), .wvalid(c_wvalid), .wready(c_wready),
		.bvalid(c_bvalid), .bready(c_bready)
	);

	inst_mem #(
		.mem_latency(mem_latency),
		.mem_words(mem_words)
	) u_mem (
		.clock(clock), .reset(reset),
		.ar(m_ar), .arvalid(m_arvalid), .arready(m_arready),
		.r(m_r), .rvalid(m_rvalid), .rready(m_rready)
	);

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect,
	input  logic [addr_w-1:0] redirect_pc,

	// cache
	output ar_chan_t          c_ar,
	output logic              c_arvalid,
	input  logic              c_arready,
	input  r_chan_t           c_r,
	input  logic              c_rvalid,
	output logic              c_rready,
	output aw_chan_t          c_aw,
	output logic              c_awvalid,
	input  logic              c_awready,
	output w_chan_t           c_w,
	output logic              c_wvalid,
	input  logic              c_wready,
	input  logic              c_bvalid,
	output logic              c_bready,

	// memory
	output ar_chan_t          m_ar,
	output logic              m_arvalid,
	input  logic              m_arready,
	input  r_chan_t           m_r,
	input  logic              m_rvalid,
	output logic              m_rready,

	output fetch_out_t        fetch_out,
	output logic              inst_valid,
	input  logic              inst_ready
);

	typedef enum logic [3:0] {
		st_idle, st_lookup, st_wait_cache, st_mem_req, st_mem_wait,
		st_fill_aw, st_fill_w, st_fill_b, st_deliver
	} state_t;

	state_t            state;
	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] lookup_addr;
	logic [addr_w-1:0] fill_data;
	logic [addr_w-1:0] miss_pc;
	logic              stale; // redirect seen while a response is owed
	logic              drop;
	logic              in_flight;

	logic c_ar_fire, c_r_fire, c_aw_fire, c_b_fire;
	logic m_ar_fire, m_r_fire;

	assign c_ar_fire = c_arvalid && c_arready;
	assign c_r_fire  = c_rvalid && c_rready;
	assign c_aw_fire = c_awvalid && c_awready;
	assign c_b_fire  = c_bvalid && c_bready;
	assign m_ar_fire = m_arvalid && m_arready;
	assign m_r_fire  = m_rvalid && m_rready;

	assign c_arvalid = state == st_lookup;
	assign c_rready  = state == st_wait_cache;
	assign m_arvalid = state == st_mem_req;
	assign m_rready  = state == st_mem_wait;
	assign c_awvalid = state == st_fill_aw;
	assign c_wvalid  = state == st_fill_w;
	assign c_bready  = state == st_fill_b;

	assign c_ar.addr = pc;
	assign m_ar.addr = lookup_addr;
	assign c_aw.addr = lookup_addr;
	assign c_w.data  = fill_data;

	assign drop      = stale || redirect;
	assign in_flight = (state != st_idle && state != st_lookup && state != st_deliver) || c_ar_fire;

	// ########################################
	// control

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= st_idle;
			pc         <= '0;
			inst_valid <= 1'b0;
			stale      <= 1'b0;
		end else begin
			if (redirect && in_flight)
				stale <= 1'b1;
			case (state)
				st_idle: state <= st_lookup;
				st_lookup: if (c_ar_fire) state <= st_wait_cache;
				st_wait_cache: if (c_r_fire) begin
					if (drop) begin
						state <= st_lookup;
						stale <= 1'b0;
					end else if (c_r.resp == resp_okay) begin
						inst_valid <= 1'b1;
						state      <= st_deliver;
					end else begin
						state <= st_mem_req; // miss
					end
				end
				st_mem_req: if (m_ar_fire) state <= st_mem_wait;
				st_mem_wait: if (m_r_fire) begin
					if (drop) begin
						state <= st_lookup;
						stale <= 1'b0;
					end else if (m_r.resp == resp_fault) begin
						inst_valid <= 1'b1; // no fill for a fault
						state      <= st_deliver;
					end else begin
						state <= st_fill_aw;
					end
				end
				st_fill_aw: if (c_aw_fire) state <= st_fill_w;
				st_fill_w: if (c_wvalid && c_wready) state <= st_fill_b;
				st_fill_b: if (c_b_fire) begin
					if (drop) begin
						state <= st_lookup;
						stale <= 1'b0;
					end else begin
						inst_valid <= 1'b1;
						state      <= st_deliver;
					end
				end
				st_deliver: if (redirect || inst_ready) begin
					inst_valid <= 1'b0;
					state      <= st_lookup;
					pc         <= pc + addr_w'(4);
				end
				default: state <= st_idle;
			endcase
			if (redirect)
				pc <= redirect_pc; // wins over the increment
		end
	end

	// ########################################
	// payload

	always_ff @(posedge clock) begin
		if (c_ar_fire)
			lookup_addr <= pc;
		if (c_r_fire && c_r.resp == resp_miss)
			miss_pc <= lookup_addr;
		if (m_r_fire)
			fill_data <= m_r.data;
		if (c_r_fire && c_r.resp == resp_okay)
			fetch_out <= '{pc: lookup_addr, inst: c_r.data, hit: 1'b1, fault: 1'b0};
		else if (m_r_fire && m_r.resp == resp_fault)
			fetch_out <= '{pc: lookup_addr, inst: m_r.data, hit: 1'b0, fault: 1'b1};
		else if (c_b_fire)
			fetch_out <= '{pc: lookup_addr, inst: fill_data, hit: 1'b0, fault: 1'b0};
	end

	a_fill_addr: assert property (@(posedge clock) disable iff (reset)
		c_aw_fire |-> c_aw.addr == miss_pc)
		else $error("[ERROR] %0t fill address differs from the missed lookup", $time);

endmodule

`default_nettype wire

// ==== inst_mem.sv ====
`default_nettype none

module inst_mem import fetch_pkg::*; #(
	parameter int mem_latency = 3,
	parameter int mem_words   = 256
) (
	input  logic     clock,
	input  logic     reset,

	input  ar_chan_t ar,
	input  logic     arvalid,
	output logic     arready,

	output r_chan_t  r,
	output logic     rvalid,
	input  logic     rready
);

	localparam int cnt_w = $clog2(mem_latency + 1);

	logic [addr_w-1:0] addr_q;
	logic [cnt_w-1:0]  count;
	logic              busy;
	logic              fault;

	logic ar_fire;
	logic r_fire;

	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
			rvalid  <= 1'b0;
			busy    <= 1'b0;
			count   <= '0;
		end else begin
			if (ar_fire) begin
				arready <= 1'b0;
				if (mem_latency == 1) begin
					rvalid <= 1'b1;
				end else begin
					busy  <= 1'b1;
					count <= cnt_w'(mem_latency - 1);
				end
			end else if (busy) begin
				count <= count - 1'b1;
				if (count == cnt_w'(1)) begin // last wait cycle
					busy   <= 1'b0;
					rvalid <= 1'b1;
				end
			end
			if (r_fire) begin
				rvalid  <= 1'b0;
				arready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire)
			addr_q <= ar.addr;
	end

	assign fault = {2'b00, addr_q[addr_w-1:2]} >= addr_w'(mem_words);

	// contents are a function of the address
	always_comb begin
		if (fault) begin
			r.data = '0;
			r.resp = resp_fault;
		end else begin
			r.data = addr_q ^ mem_pattern;
			r.resp = resp_okay;
		end
	end

	a_r_hold: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(r))
		else $error("[ERROR] %0t inst_mem response changed before rready", $time);

endmodule

`default_nettype wire

// ==== icache.sv ====
`default_nettype none

module icache import fetch_pkg::*; (
	input  logic     clock,
	input  logic     reset,

	input  ar_chan_t ar,
	input  logic     arvalid,
	output logic     arready,

	output r_chan_t  r,
	output logic     rvalid,
	input  logic     rready,

	input  aw_chan_t aw,
	input  logic     awvalid,
	output logic     awready,

	input  w_chan_t  w,
	input  logic     wvalid,
	output logic     wready,

	output logic     bvalid,
	input  logic     bready
);

	localparam int lines = 2 ** index_len;

	logic [addr_w-1:0]  data_mem [lines];
	logic [tag_len-1:0] tag_mem  [lines];
	logic [lines-1:0]   valid_bits;

	cache_addr_u rd_addr;
	cache_addr_u wr_addr; // held from aw until the w beat
	logic        hit;

	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign b_fire  = bvalid && bready;

	assign rd_addr.raw = ar.addr;
	assign hit = valid_bits[rd_addr.f.index] && (tag_mem[rd_addr.f.index] == rd_addr.f.tag);

	// ########################################
	// read side

	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
			rvalid  <= 1'b0;
		end else begin
			if (ar_fire) begin
				arready <= 1'b0; // one read in flight
				rvalid  <= 1'b1;
			end else if (r_fire) begin
				arready <= 1'b1;
				rvalid  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			r.data <= data_mem[rd_addr.f.index];
			r.resp <= hit ? resp_okay : resp_miss;
		end
	end

	// ########################################
	// fill side

	always_ff @(posedge clock) begin
		if (reset) begin
			awready <= 1'b1;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			if (aw_fire) begin
				awready <= 1'b0;
				wready  <= 1'b1;
			end
			if (w_fire) begin
				wready <= 1'b0;
				bvalid <= 1'b1;
			end
			if (b_fire) begin
				bvalid  <= 1'b0;
				awready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (aw_fire)
			wr_addr.raw <= aw.addr;
	end

	always_ff @(posedge clock) begin
		if (reset)
			valid_bits <= '0;
		else if (w_fire)
			valid_bits[wr_addr.f.index] <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (w_fire) begin
			data_mem[wr_addr.f.index] <= w.data;
			tag_mem[wr_addr.f.index]  <= wr_addr.f.tag;
		end
	end

	a_one_read: assert property (@(posedge clock) disable iff (reset)
		!(arready && rvalid))
		else $error("[ERROR] %0t icache accepting a read with a response pending", $time);

	a_w_after_aw: assert property (@(posedge clock) disable iff (reset)
		wready |-> !awready && !bvalid)
		else $error("[ERROR] %0t icache wready without an open aw", $time);

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	localparam int addr_w     = 32;
	localparam int offset_len = 2;
	localparam int index_len  = 4;
	localparam int tag_len    = addr_w - offset_len - index_len;

	localparam logic [addr_w-1:0] mem_pattern = 32'h5a5a_0000; // xor'ed into every word

	typedef enum logic [1:0] {
		resp_okay  = 2'b00,
		resp_miss  = 2'b10, // cache only
		resp_fault = 2'b11  // memory only
	} resp_t;

	// cache view of an address
	typedef struct packed {
		logic [tag_len-1:0]    tag;
		logic [index_len-1:0]  index;
		logic [offset_len-1:0] offset;
	} cache_addr_s;

	typedef union packed {
		logic [addr_w-1:0] raw;
		cache_addr_s       f;
	} cache_addr_u;

	typedef struct packed {
		logic [addr_w-1:0] addr;
	} ar_chan_t;

	typedef struct packed {
		logic [addr_w-1:0] data;
		resp_t             resp;
	} r_chan_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
	} aw_chan_t;

	typedef struct packed {
		logic [addr_w-1:0] data;
	} w_chan_t;

	typedef struct packed {
		logic [addr_w-1:0] pc;
		logic [addr_w-1:0] inst;
		logic              hit;
		logic              fault;
	} fetch_out_t;

endpackage

`default_nettype wire
